// ==== tb.f ====
+incdir+include
design/lsq_pkg.sv
design/load_alloc.sv
design/load_slot.sv
design/store_queue.sv
design/mem_sequencer.sv
design/lsq_top.sv
test/tb_clock.sv
test/lsq_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = lsq_tb
FILELIST  = tb.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== test/lsq_tb.sv ====
`timescale 1ns/1ps
`include "lsq_defs.svh"

module lsq_tb;

    logic                           clk;
    logic                           rst;
    logic                           load_dispatch, store_dispatch;
    logic [2:0]                     dispatch_funct3;
    logic [`LSQ_ROB_BITS-1:0]       dispatch_rob;
    logic [`LSQ_PHYS_BITS-1:0]      dispatch_pd;
    logic                           addr_valid, addr_is_store;
    logic [`LSQ_LOAD_IDX_BITS-1:0]  addr_idx;
    logic [`LSQ_XLEN-1:0]           addr, store_wdata, d_rdata, d_addr, d_wdata, result_value;
    logic [`LSQ_ROB_BITS-1:0]       commit_rob, result_rob;
    logic                           d_resp, full, result_valid, result_is_store;
    logic [`LSQ_LOAD_IDX_BITS-1:0]  load_idx;
    logic [`LSQ_STORE_IDX_BITS-1:0] store_idx;
    logic [3:0]                     d_rmask, d_wmask;
    logic [`LSQ_PHYS_BITS-1:0]      result_pd;

    logic [31:0]  lfsr = 32'hd5c499b2;
    int           errors, results, dispatched;
    logic [4:0]   next_rob, hold_rob;
    bit           hold;
    logic [31:0]  gold_mem [4];
    logic [31:0]  cache_mem [4];
    // expectations per ROB number
    bit           exp_pending [32];
    bit           exp_is_store [32];
    logic [5:0]   exp_pd [32];
    logic [31:0]  exp_value [32], exp_addr [32], exp_wdata [32];
    logic [3:0]   exp_mask [32];
    int           outstanding [$];
    int           store_robs [$];
    // entries whose address has not been delivered yet
    bit           pend_st [$];
    int           pend_idx [$];
    logic [31:0]  pend_addr [$], pend_data [$];
    int           op_f3, op_k, op_off;
    logic [31:0]  op_data;
    logic [5:0]   op_pd;
    // last load request, matched to its result later
    logic [3:0]   req_rmask;
    logic [31:0]  req_addr;

    tb_clock u_clock (.clk);

    lsq_top DUT (.*);

    // galois lfsr, one step per bit
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input int k);
        logic [31:0] a;
        a = 32'h100 + 4 * k;
        return (a * 32'h9e3779b1) ^ 32'h5a5a0f0f;
    endfunction

    // RV32 load result from a memory word
    function automatic logic [31:0] load_ref(input logic [31:0] word, input int off,
                                             input int f3);
        logic [31:0] s;
        s = word >> (8 * off);
        case (f3)
            0: return {{24{s[7]}}, s[7:0]};
            1: return {{16{s[15]}}, s[15:0]};
            4: return {24'h0, s[7:0]};
            5: return {16'h0, s[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic logic [3:0] byte_mask(input int f3, input int off);
        logic [3:0] m;
        int n;
        n = 1 << (f3 % 4);
        m = '0;
        for (int b = 0; b < 4; b++)
            if (b >= off && b < off + n)
                m[b] = 1'b1;
        return m;
    endfunction

    function automatic logic [31:0] lane_data(input logic [31:0] data, input int off,
                                              input logic [3:0] m);
        logic [31:0] w;
        w = '0;
        for (int b = 0; b < 4; b++)
            if (m[b])
                w[8*b +: 8] = data[8*(b-off) +: 8];
        return w;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic timed_out(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
        $display("errors: %0d, results: %0d of %0d", errors, results, dispatched);
        $display("Test failed");
        $finish;
    endtask

    task automatic pick_op(input bit st);
        int r;
        r = rand_bits(3);
        op_f3 = st ? (r % 3) : (((r % 5) > 2) ? (r % 5) + 1 : (r % 5));
        case (op_f3 % 4)
            0: op_off = rand_bits(2);
            1: op_off = 2 * rand_bits(1);
            default: op_off = 0;
        endcase
        op_k = rand_bits(2);
        op_data = rand_bits(32);
        op_pd = rand_bits(6);
    endtask

    task automatic record_dispatch(input bit st);
        int r;
        logic [31:0] a;
        logic [3:0] m;
        r = next_rob;
        a = 32'h100 + 4 * op_k + op_off;
        m = byte_mask(op_f3, op_off);
        exp_pending[r] = 1'b1;
        exp_is_store[r] = st;
        exp_addr[r] = {a[31:2], 2'b00};
        exp_mask[r] = m;
        outstanding.push_back(r);
        pend_st.push_back(st);
        pend_addr.push_back(a);
        pend_data.push_back(op_data);
        if (st)
        begin
            exp_pd[r] = '0;
            exp_value[r] = '0;
            exp_wdata[r] = lane_data(op_data, op_off, m);
            store_robs.push_back(r);
            pend_idx.push_back(store_idx);
            // program-order image
            for (int b = 0; b < 4; b++)
                if (m[b])
                    gold_mem[op_k][8*b +: 8] = exp_wdata[r][8*b +: 8];
        end
        else
        begin
            exp_pd[r] = op_pd;
            exp_value[r] = load_ref(gold_mem[op_k], op_off, op_f3);
            pend_idx.push_back(load_idx);
        end
        next_rob++;
        dispatched++;
    endtask

    // two cycles: strobes for one cycle, then an idle cycle; apos < 0 means no address
    task automatic tick(input bit disp, input bit st, input int apos);
        @(posedge clk);
        if (disp)
        begin
            load_dispatch   <= !st;
            store_dispatch  <= st;
            dispatch_funct3 <= 3'(op_f3);
            dispatch_rob    <= next_rob;
            dispatch_pd     <= op_pd;
        end
        if (apos >= 0)
        begin
            addr_valid    <= 1'b1;
            addr_is_store <= pend_st[apos];
            addr_idx      <= 3'(pend_idx[apos]);
            addr          <= pend_addr[apos];
            store_wdata   <= pend_data[apos];
        end
        @(negedge clk);
        if (apos >= 0)
        begin
            pend_st.delete(apos);
            pend_idx.delete(apos);
            pend_addr.delete(apos);
            pend_data.delete(apos);
        end
        if (disp)
            record_dispatch(st);
        @(posedge clk);
        load_dispatch  <= 1'b0;
        store_dispatch <= 1'b0;
        addr_valid     <= 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (outstanding.size() > 0 || pend_st.size() > 0)
        begin
            if (pend_st.size() > 0)
                tick(1'b0, 1'b0, 0);
            else
                @(negedge clk);
            n++;
            if (n > 3000)
                timed_out("outstanding operations to finish");
        end
    endtask

    task automatic wait_full_low();
        int n;
        n = 0;
        while (full)
        begin
            @(negedge clk);
            n++;
            if (n > 200)
                timed_out("full to fall");
        end
    endtask

    // queue full with commit held back
    task automatic fill_test(input bit loads);
        hold = 1'b1;
        hold_rob = next_rob + 5'd16;
        if (loads)
        begin
            pick_op(1'b1);
            tick(1'b1, 1'b1, -1);
        end
        for (int i = 0; i < 8; i++)
        begin
            pick_op(!loads);
            tick(1'b1, !loads, (pend_st.size() > 0) ? 0 : -1);
            check("full", full, (i == 7));
        end
        tick(1'b0, 1'b0, 0);
        hold = 1'b0;
        wait_full_low();
        wait_drain();
    endtask

    // cache model with random latency
    initial
    begin
        int lat;
        int r;
        logic [31:0] rdata;
        d_resp = 1'b0;
        d_rdata = '0;
        forever
        begin
            @(negedge clk);
            if (!rst && (d_rmask != 0 || d_wmask != 0))
            begin
                check("d_addr[1:0]", d_addr[1:0], 0);
                if (d_rmask != 0)
                begin
                    req_rmask = d_rmask;
                    req_addr  = d_addr;
                end
                if (d_wmask != 0)
                begin
                    if (store_robs.size() == 0)
                    begin
                        errors++;
                        $display("store request with no store outstanding");
                    end
                    else
                    begin
                        r = store_robs.pop_front();
                        check("d_addr", d_addr, exp_addr[r]);
                        check("d_wmask", d_wmask, exp_mask[r]);
                        check("d_wdata", d_wdata, exp_wdata[r]);
                        check("commit_rob", commit_rob, r);
                        for (int b = 0; b < 4; b++)
                            if (d_wmask[b])
                                cache_mem[d_addr[3:2]][8*b +: 8] = d_wdata[8*b +: 8];
                    end
                end
                rdata = cache_mem[d_addr[3:2]];
                lat = 1 + rand_bits(2);
                repeat (lat) @(posedge clk);
                d_resp  <= 1'b1;
                d_rdata <= rdata;
                @(posedge clk);
                d_resp  <= 1'b0;
            end
        end
    end

    // result checker
    initial
    begin
        int r;
        forever
        begin
            @(negedge clk);
            if (!rst && result_valid)
            begin
                r = result_rob;
                results++;
                if (!exp_pending[r])
                begin
                    errors++;
                    $display("result for ROB %0d, which has no operation outstanding", r);
                end
                else
                begin
                    check("result_is_store", result_is_store, exp_is_store[r]);
                    check("result_pd", result_pd, exp_pd[r]);
                    check("result_value", result_value, exp_value[r]);
                    if (!exp_is_store[r])
                    begin
                        check("d_rmask", req_rmask, exp_mask[r]);
                        check("d_addr", req_addr, exp_addr[r]);
                    end
                    exp_pending[r] = 1'b0;
                    foreach (outstanding[i])
                        if (outstanding[i] == r)
                        begin
                            outstanding.delete(i);
                            break;
                        end
                end
            end
        end
    end

    // ROB head follows the oldest outstanding operation
    initial
    begin
        commit_rob = '0;
        forever
        begin
            @(posedge clk);
            commit_rob <= hold ? hold_rob :
                          ((outstanding.size() > 0) ? 5'(outstanding[0]) : next_rob);
        end
    end

    initial
    begin
        int iter;
        bit st;
        bit disp;
        int apos;
        rst = 1'b1;
        load_dispatch = 1'b0;
        store_dispatch = 1'b0;
        dispatch_funct3 = '0;
        dispatch_rob = '0;
        dispatch_pd = '0;
        addr_valid = 1'b0;
        addr_is_store = 1'b0;
        addr_idx = '0;
        addr = '0;
        store_wdata = '0;
        next_rob = '0;
        hold = 1'b0;
        for (int k = 0; k < 4; k++)
        begin
            gold_mem[k] = fill_word(k);
            cache_mem[k] = fill_word(k);
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("full", full, 0);
        check("result_valid", result_valid, 0);
        check("d_rmask", d_rmask, 0);
        check("d_wmask", d_wmask, 0);

        // store then load to the same word, load address delivered first
        op_f3 = 2;
        op_k = 2;
        op_off = 0;
        op_data = 32'hc0ffee11;
        op_pd = '0;
        tick(1'b1, 1'b1, -1);
        op_f3 = 0;
        op_off = 3;
        op_pd = 6'd9;
        tick(1'b1, 1'b0, -1);
        tick(1'b0, 1'b0, 1);
        tick(1'b0, 1'b0, 0);
        wait_drain();

        fill_test(1'b0);
        fill_test(1'b1);

        // random mixed run
        iter = 0;
        while (dispatched < 420)
        begin
            st = rand_bits(1);
            disp = !full && rand_bits(1);
            apos = -1;
            if (pend_st.size() > 0 && rand_bits(1))
                apos = rand_bits(4) % pend_st.size();
            if (disp)
                pick_op(st);
            tick(disp, st, apos);
            iter++;
            if (iter > 20000)
                timed_out("the random run to dispatch its operations");
        end
        wait_drain();
        repeat (4) @(negedge clk);
        check("result count", results, dispatched);

        $display("errors: %0d, results: %0d of %0d", errors, results, dispatched);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock
#(
    parameter realtime PERIOD = 100ns
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD / 2) clk = ~clk;
    end

endmodule

// ==== design/lsq_top.sv ====
`timescale 1ns/1ps
`include "lsq_defs.svh"

module lsq_top
    import lsq_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            load_dispatch,
    input  logic                            store_dispatch,
    input  logic [2:0]                      dispatch_funct3,
    input  logic [`LSQ_ROB_BITS-1:0]        dispatch_rob,
    input  logic [`LSQ_PHYS_BITS-1:0]       dispatch_pd,
    input  logic                            addr_valid,
    input  logic                            addr_is_store,
    input  logic [`LSQ_LOAD_IDX_BITS-1:0]   addr_idx,
    input  logic [`LSQ_XLEN-1:0]            addr,
    input  logic [`LSQ_XLEN-1:0]            store_wdata,
    input  logic [`LSQ_ROB_BITS-1:0]        commit_rob,
    input  logic [`LSQ_XLEN-1:0]            d_rdata,
    input  logic                            d_resp,
    output logic                            full,
    output logic [`LSQ_LOAD_IDX_BITS-1:0]   load_idx,
    output logic [`LSQ_STORE_IDX_BITS-1:0]  store_idx,
    output logic [`LSQ_XLEN-1:0]            d_addr,
    output logic [`LSQ_XLEN/8-1:0]          d_rmask,
    output logic [`LSQ_XLEN/8-1:0]          d_wmask,
    output logic [`LSQ_XLEN-1:0]            d_wdata,
    output logic                            result_valid,
    output logic [`LSQ_ROB_BITS-1:0]        result_rob,
    output logic [`LSQ_PHYS_BITS-1:0]       result_pd,
    output logic [`LSQ_XLEN-1:0]            result_value,
    output logic                            result_is_store
);

    logic [`LSQ_LOAD_DEPTH-1:0]     alloc, busy, ready, free;
    logic                           load_full, store_full, head_ready, store_retire;
    logic [`LSQ_STORE_IDX_BITS:0]   enq_count, ret_count;
    logic [`LSQ_XLEN-1:0]           slot_addr   [`LSQ_LOAD_DEPTH];
    load_funct_t                    slot_funct3 [`LSQ_LOAD_DEPTH];
    logic [`LSQ_ROB_BITS-1:0]       slot_rob    [`LSQ_LOAD_DEPTH];
    logic [`LSQ_PHYS_BITS-1:0]      slot_pd     [`LSQ_LOAD_DEPTH];
    logic [`LSQ_XLEN-1:0]           head_addr, head_data;
    store_funct_t                   head_funct3;
    logic [`LSQ_ROB_BITS-1:0]       head_rob;

    assign full = load_full || store_full;

    load_alloc u_alloc (.*);

    for (genvar i = 0; i < `LSQ_LOAD_DEPTH; i++)
    begin : g_slot
        load_slot #(.SLOT_ID(i)) u_slot (
            .clk, .rst, .alloc(alloc[i]), .free(free[i]),
            .dispatch_funct3, .dispatch_rob, .dispatch_pd, .enq_count, .ret_count,
            .addr_valid, .addr_is_store, .addr_idx, .addr,
            .busy(busy[i]), .ready(ready[i]), .slot_addr(slot_addr[i]),
            .slot_funct3(slot_funct3[i]), .slot_rob(slot_rob[i]), .slot_pd(slot_pd[i])
        );
    end

    store_queue u_sq (
        .clk, .rst, .store_dispatch, .dispatch_funct3, .dispatch_rob,
        .addr_valid, .addr_is_store, .addr_idx(addr_idx[`LSQ_STORE_IDX_BITS-1:0]),
        .addr, .store_wdata, .commit_rob, .store_retire, .store_idx, .store_full,
        .enq_count, .ret_count, .head_ready, .head_addr, .head_funct3, .head_data, .head_rob
    );

    mem_sequencer u_seq (.*);

endmodule

// ==== design/mem_sequencer.sv ====
`timescale 1ns/1ps
`include "lsq_defs.svh"

module mem_sequencer
    import lsq_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic [`LSQ_LOAD_DEPTH-1:0]      ready,
    input  logic [`LSQ_XLEN-1:0]            slot_addr   [`LSQ_LOAD_DEPTH],
    input  load_funct_t                     slot_funct3 [`LSQ_LOAD_DEPTH],
    input  logic [`LSQ_ROB_BITS-1:0]        slot_rob    [`LSQ_LOAD_DEPTH],
    input  logic [`LSQ_PHYS_BITS-1:0]       slot_pd     [`LSQ_LOAD_DEPTH],
    input  logic                            head_ready,
    input  logic [`LSQ_XLEN-1:0]            head_addr,
    input  store_funct_t                    head_funct3,
    input  logic [`LSQ_XLEN-1:0]            head_data,
    input  logic [`LSQ_ROB_BITS-1:0]        head_rob,
    input  logic [`LSQ_XLEN-1:0]            d_rdata,
    input  logic                            d_resp,
    output logic [`LSQ_LOAD_DEPTH-1:0]      free,
    output logic                            store_retire,
    output logic [`LSQ_XLEN-1:0]            d_addr,
    output logic [`LSQ_XLEN/8-1:0]          d_rmask,
    output logic [`LSQ_XLEN/8-1:0]          d_wmask,
    output logic [`LSQ_XLEN-1:0]            d_wdata,
    output logic                            result_valid,
    output logic [`LSQ_ROB_BITS-1:0]        result_rob,
    output logic [`LSQ_PHYS_BITS-1:0]       result_pd,
    output logic [`LSQ_XLEN-1:0]            result_value,
    output logic                            result_is_store
);

    mem_state_t                     state;
    logic [`LSQ_LOAD_IDX_BITS-1:0]  pick_idx;
    logic [`LSQ_LOAD_IDX_BITS-1:0]  sel;
    logic [1:0]                     offset;
    logic [`LSQ_XLEN-1:0]           lane_word;
    logic [`LSQ_XLEN-1:0]           load_value;
    logic [`LSQ_XLEN-1:0]           store_lanes;

    // size bits of funct3 are shared by loads and stores
    function automatic logic [`LSQ_XLEN/8-1:0] access_mask(input logic [1:0] size,
                                                           input logic [1:0] off);
        case (size)
            2'b00:   access_mask = 4'b0001 << off;
            2'b01:   access_mask = 4'b0011 << off;
            default: access_mask = 4'b1111;
        endcase
    endfunction

    always_comb
    begin
        pick_idx = '0;
        for (int i = `LSQ_LOAD_DEPTH - 1; i >= 0; i--)
        begin
            if (ready[i])
                pick_idx = `LSQ_LOAD_IDX_BITS'(i);
        end
    end

    // store data moved into its byte lanes
    always_comb
    begin
        case (head_funct3)
            sb:      store_lanes = {{(`LSQ_XLEN-8){1'b0}}, head_data[7:0]} << (8 * head_addr[1:0]);
            sh:      store_lanes = {{(`LSQ_XLEN-16){1'b0}}, head_data[15:0]} << (8 * head_addr[1:0]);
            default: store_lanes = head_data;
        endcase
    end

    // pick the addressed lane, then extend
    always_comb
    begin
        lane_word = d_rdata >> (8 * offset);
        case (slot_funct3[sel])
            lb:      load_value = {{(`LSQ_XLEN-8){lane_word[7]}}, lane_word[7:0]};
            lbu:     load_value = {{(`LSQ_XLEN-8){1'b0}}, lane_word[7:0]};
            lh:      load_value = {{(`LSQ_XLEN-16){lane_word[15]}}, lane_word[15:0]};
            lhu:     load_value = {{(`LSQ_XLEN-16){1'b0}}, lane_word[15:0]};
            default: load_value = d_rdata;
        endcase
    end

    // slot free and store retire land on the same edge as result_valid
    always_comb
    begin
        free = '0;
        if (state == wait_load && d_resp)
            free[sel] = 1'b1;
    end
    assign store_retire = (state == wait_store) && d_resp;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state        <= pick_load;
            d_rmask      <= '0;
            d_wmask      <= '0;
            result_valid <= 1'b0;
        end
        else
        begin
            d_rmask      <= '0;
            d_wmask      <= '0;
            result_valid <= 1'b0;
            case (state)
                pick_load:
                begin
                    if (|ready)
                    begin
                        d_rmask <= access_mask(slot_funct3[pick_idx][1:0], slot_addr[pick_idx][1:0]);
                        state   <= wait_load;
                    end
                    else
                        state <= pick_store;
                end
                pick_store:
                begin
                    if (head_ready)
                    begin
                        d_wmask <= access_mask(head_funct3[1:0], head_addr[1:0]);
                        state   <= wait_store;
                    end
                    else
                        state <= pick_load;
                end
                wait_load:
                begin
                    if (d_resp)
                    begin
                        result_valid <= 1'b1;
                        state        <= pick_store;
                    end
                end
                default:
                begin
                    if (d_resp)
                    begin
                        result_valid <= 1'b1;
                        state        <= pick_load;
                    end
                end
            endcase
        end
    end

    // request and result payload
    always_ff @(posedge clk)
    begin
        if (state == pick_load && |ready)
        begin
            sel     <= pick_idx;
            offset  <= slot_addr[pick_idx][1:0];
            d_addr  <= {slot_addr[pick_idx][`LSQ_XLEN-1:2], 2'b00};
            d_wdata <= '0;
        end
        else if (state == pick_store && head_ready)
        begin
            d_addr  <= {head_addr[`LSQ_XLEN-1:2], 2'b00};
            d_wdata <= store_lanes;
        end
        if (state == wait_load && d_resp)
        begin
            result_rob      <= slot_rob[sel];
            result_pd       <= slot_pd[sel];
            result_value    <= load_value;
            result_is_store <= 1'b0;
        end
        else if (state == wait_store && d_resp)
        begin
            result_rob      <= head_rob;
            result_pd       <= '0;
            result_value    <= '0;
            result_is_store <= 1'b1;
        end
    end

    // one request in flight, so a response outside a wait state is stray
    resp_in_wait: assert property (@(posedge clk) disable iff (rst)
        d_resp |-> (state == wait_load || state == wait_store));

endmodule

// ==== design/store_queue.sv ====
`timescale 1ns/1ps
`include "lsq_defs.svh"

module store_queue
    import lsq_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            store_dispatch,
    input  logic [2:0]                      dispatch_funct3,
    input  logic [`LSQ_ROB_BITS-1:0]        dispatch_rob,
    input  logic                            addr_valid,
    input  logic                            addr_is_store,
    input  logic [`LSQ_STORE_IDX_BITS-1:0]  addr_idx,
    input  logic [`LSQ_XLEN-1:0]            addr,
    input  logic [`LSQ_XLEN-1:0]            store_wdata,
    input  logic [`LSQ_ROB_BITS-1:0]        commit_rob,
    input  logic                            store_retire,
    output logic [`LSQ_STORE_IDX_BITS-1:0]  store_idx,
    output logic                            store_full,
    output logic [`LSQ_STORE_IDX_BITS:0]    enq_count,
    output logic [`LSQ_STORE_IDX_BITS:0]    ret_count,
    output logic                            head_ready,
    output logic [`LSQ_XLEN-1:0]            head_addr,
    output store_funct_t                    head_funct3,
    output logic [`LSQ_XLEN-1:0]            head_data,
    output logic [`LSQ_ROB_BITS-1:0]        head_rob
);

    localparam int IDX = `LSQ_STORE_IDX_BITS;

    // one extra bit on each counter tells full from empty
    logic [IDX:0]                  head;
    logic [IDX:0]                  tail;
    logic [IDX-1:0]                head_ptr;
    logic [`LSQ_STORE_DEPTH-1:0]   addr_known;

    logic [`LSQ_XLEN-1:0]          sq_addr  [`LSQ_STORE_DEPTH];
    logic [`LSQ_XLEN-1:0]          sq_data  [`LSQ_STORE_DEPTH];
    store_funct_t                  sq_funct [`LSQ_STORE_DEPTH];
    logic [`LSQ_ROB_BITS-1:0]      sq_rob   [`LSQ_STORE_DEPTH];

    assign head_ptr   = head[IDX-1:0];
    assign store_idx  = tail[IDX-1:0];
    assign enq_count  = tail;
    assign ret_count  = head;
    assign store_full = (head[IDX-1:0] == tail[IDX-1:0]) && (head[IDX] != tail[IDX]);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            head       <= '0;
            tail       <= '0;
            addr_known <= '0;
        end
        else
        begin
            if (store_dispatch)
            begin
                tail                 <= tail + 1'b1;
                addr_known[store_idx] <= 1'b0;
            end
            if (addr_valid && addr_is_store)
                addr_known[addr_idx] <= 1'b1;
            if (store_retire)
                head <= head + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (store_dispatch)
        begin
            sq_funct[store_idx] <= store_funct_t'(dispatch_funct3);
            sq_rob[store_idx]   <= dispatch_rob;
        end
        if (addr_valid && addr_is_store)
        begin
            sq_addr[addr_idx] <= addr;
            sq_data[addr_idx] <= store_wdata;
        end
    end

    // head may write memory only once the ROB has reached it
    assign head_ready  = (head != tail) && addr_known[head_ptr] && (sq_rob[head_ptr] == commit_rob);
    assign head_addr   = sq_addr[head_ptr];
    assign head_funct3 = sq_funct[head_ptr];
    assign head_data   = sq_data[head_ptr];
    assign head_rob    = sq_rob[head_ptr];

    retire_needs_ready: assert property (@(posedge clk) disable iff (rst)
        store_retire |-> head_ready);

    // tail must not overrun the head
    no_store_when_full: assert property (@(posedge clk) disable iff (rst)
        store_dispatch |-> !store_full);

endmodule

// ==== design/load_slot.sv ====
`timescale 1ns/1ps
`include "lsq_defs.svh"

module load_slot
    import lsq_pkg::*;
#(
    parameter int SLOT_ID = 0
)
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            alloc,
    input  logic                            free,
    input  logic [2:0]                      dispatch_funct3,
    input  logic [`LSQ_ROB_BITS-1:0]        dispatch_rob,
    input  logic [`LSQ_PHYS_BITS-1:0]       dispatch_pd,
    input  logic [`LSQ_STORE_IDX_BITS:0]    enq_count,
    input  logic [`LSQ_STORE_IDX_BITS:0]    ret_count,
    input  logic                            addr_valid,
    input  logic                            addr_is_store,
    input  logic [`LSQ_LOAD_IDX_BITS-1:0]   addr_idx,
    input  logic [`LSQ_XLEN-1:0]            addr,
    output logic                            busy,
    output logic                            ready,
    output logic [`LSQ_XLEN-1:0]            slot_addr,
    output load_funct_t                     slot_funct3,
    output logic [`LSQ_ROB_BITS-1:0]        slot_rob,
    output logic [`LSQ_PHYS_BITS-1:0]       slot_pd
);

    logic                          addr_known;
    logic                          addr_hit;
    logic [`LSQ_STORE_IDX_BITS:0]  store_mark;
    logic [`LSQ_STORE_IDX_BITS:0]  mark_dist;

    assign addr_hit = addr_valid && !addr_is_store &&
                      (addr_idx == `LSQ_LOAD_IDX_BITS'(SLOT_ID));

    // top bit clear means ret_count has caught up with the mark
    assign mark_dist = ret_count - store_mark;
    assign ready = busy && addr_known && !mark_dist[`LSQ_STORE_IDX_BITS];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy       <= 1'b0;
            addr_known <= 1'b0;
        end
        else if (alloc)
        begin
            busy       <= 1'b1;
            addr_known <= 1'b0;
        end
        else
        begin
            if (free)
                busy <= 1'b0;
            if (addr_hit)
                addr_known <= 1'b1;
        end
    end

    // operation fields
    always_ff @(posedge clk)
    begin
        if (alloc)
        begin
            slot_funct3 <= load_funct_t'(dispatch_funct3);
            slot_rob    <= dispatch_rob;
            slot_pd     <= dispatch_pd;
            store_mark  <= enq_count;
        end
        if (addr_hit)
            slot_addr <= addr;
    end

    // the sequencer only frees a slot it picked while ready
    free_while_busy: assert property (@(posedge clk) disable iff (rst) free |-> busy);

endmodule

// ==== design/load_alloc.sv ====
`timescale 1ns/1ps
`include "lsq_defs.svh"

module load_alloc
    import lsq_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            load_dispatch,
    input  logic                            store_dispatch,
    input  logic [`LSQ_LOAD_DEPTH-1:0]      busy,
    output logic [`LSQ_LOAD_DEPTH-1:0]      alloc,
    output logic [`LSQ_LOAD_IDX_BITS-1:0]   load_idx,
    output logic                            load_full
);

    assign load_full = &busy;

    // lowest free slot wins
    always_comb
    begin
        load_idx = '0;
        for (int i = `LSQ_LOAD_DEPTH - 1; i >= 0; i--)
        begin
            if (!busy[i])
                load_idx = `LSQ_LOAD_IDX_BITS'(i);
        end
    end

    always_comb
    begin
        alloc = '0;
        if (load_dispatch && !load_full)
            alloc[load_idx] = 1'b1;
    end

    // dispatch source must honour full
    no_load_when_full: assert property (@(posedge clk) disable iff (rst)
        load_dispatch |-> !load_full);

    one_dispatch_kind: assert property (@(posedge clk) disable iff (rst)
        !(load_dispatch && store_dispatch));

endmodule

// ==== design/lsq_pkg.sv ====
package lsq_pkg;

    // memory sequencer states
    typedef enum logic [1:0] {
        pick_load  = 2'b00,
        pick_store = 2'b01,
        wait_load  = 2'b10,
        wait_store = 2'b11
    } mem_state_t;

    // RV32 load funct3 codes
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct_t;

    // RV32 store funct3 codes
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct_t;

endpackage

// ==== include/lsq_defs.svh ====
`ifndef LSQ_DEFS_SVH
`define LSQ_DEFS_SVH

// data and address width
`define LSQ_XLEN 32

// load side, one slot per in-flight load
`define LSQ_LOAD_DEPTH 8
`define LSQ_LOAD_IDX_BITS 3

// store side, circular buffer
`define LSQ_STORE_DEPTH 8
`define LSQ_STORE_IDX_BITS 3

// core-side tags
`define LSQ_ROB_BITS 5
`define LSQ_PHYS_BITS 6

`endif
